/* soc_params.svh */
////////////////////////////////////////////////////////////////////////////
// system constants for the memory-mapped subsystem
// bus widths, boot RAM depth, I/O register map and reset divisor
////////////////////////////////////////////////////////////////////////////

`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// boot RAM, byte addresses 0 to 1023
`define SOC_BRAM_WORDS 256

// I/O register map
`define SOC_UART_TX_ADDR  32'h1000_0000
`define SOC_UART_LSR_ADDR 32'h1000_0005
`define SOC_DIV_ADDR      32'h1000_0010
`define SOC_CPU_FREQ_ADDR 32'h1000_0014
`define SOC_MEM_SIZE_ADDR 32'h1000_0018

// values seen by software
`define SOC_SYSTEM_CLK 50_000_000
`define SOC_MEM_SIZE   1024

// divisor after reset, clocks per UART bit
`define SOC_DIV_RESET 16

`endif

/* soc_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// bus word types and the decoded target enumeration
////////////////////////////////////////////////////////////////////////////

package soc_pkg;

  // byte address as issued by the load/store port
  typedef logic [31:0] addr_t;

  // one data word
  typedef logic [31:0] data_t;

  // one strobe per byte lane, all zero for a read
  typedef logic [3:0] wstrb_t;

  // targets the decoder can select
  typedef enum logic [2:0] {
    tgt_ram       = 3'd0,
    tgt_uart_data = 3'd1,
    tgt_uart_lsr  = 3'd2,
    tgt_div       = 3'd3,
    tgt_freq      = 3'd4,
    tgt_mem_size  = 3'd5,
    tgt_unmapped  = 3'd6
  } target_e;

endpackage

/* soc_addr_decode.sv */
////////////////////////////////////////////////////////////////////////////
// request stage
// classifies the address, registers the request and its target,
// blocks a second acceptance of the held request
////////////////////////////////////////////////////////////////////////////

`include "soc_params.svh"

module soc_addr_decode import soc_pkg::*; (
  input  logic    clk,
  input  logic    resetn,
  input  logic    mem_valid_i,
  input  addr_t   mem_addr_i,
  input  data_t   mem_wdata_i,
  input  wstrb_t  mem_wstrb_i,
  output logic    req_fire_o,
  output target_e req_target_o,
  output addr_t   req_addr_o,
  output data_t   req_wdata_o,
  output wstrb_t  req_wstrb_o
);

  target_e target;
  logic    busy_q;
  logic    fire_q;
  logic    accept;

  // address map
  always_comb begin
    if (mem_addr_i < addr_t'(`SOC_BRAM_WORDS * 4)) begin
      target = tgt_ram;
    end else begin
      case (mem_addr_i)
        `SOC_UART_TX_ADDR:  target = tgt_uart_data;
        `SOC_UART_LSR_ADDR: target = tgt_uart_lsr;
        `SOC_DIV_ADDR:      target = tgt_div;
        `SOC_CPU_FREQ_ADDR: target = tgt_freq;
        `SOC_MEM_SIZE_ADDR: target = tgt_mem_size;
        default:            target = tgt_unmapped;
      endcase
    end
  end

  assign accept = mem_valid_i && !busy_q;

  // busy spans acceptance up to the response cycle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      req_fire_o <= 1'b0;
      fire_q     <= 1'b0;
      busy_q     <= 1'b0;
    end else begin
      req_fire_o <= accept;
      fire_q     <= req_fire_o;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (fire_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_target_o <= target;
      req_addr_o   <= mem_addr_i;
      req_wdata_o  <= mem_wdata_i;
      req_wstrb_o  <= mem_wstrb_i;
    end
  end

  // one request in flight, so no back-to-back fire
  a_fire_single : assert property (@(posedge clk) disable iff (!resetn)
    req_fire_o |=> !req_fire_o);

endmodule

/* soc_boot_ram.sv */
////////////////////////////////////////////////////////////////////////////
// boot RAM
// word array with byte lane writes and a registered read port
////////////////////////////////////////////////////////////////////////////

`include "soc_params.svh"

module soc_boot_ram import soc_pkg::*; (
  input  logic    clk,
  input  logic    req_fire_i,
  input  target_e req_target_i,
  input  addr_t   req_addr_i,
  input  data_t   req_wdata_i,
  input  wstrb_t  req_wstrb_i,
  output data_t   ram_rdata_o
);

  localparam int RAM_AW = $clog2(`SOC_BRAM_WORDS);

  data_t             mem [`SOC_BRAM_WORDS];
  logic [RAM_AW-1:0] word_idx;
  logic              sel;

  // byte address to word index
  assign word_idx = req_addr_i[RAM_AW+1:2];
  assign sel      = req_fire_i && (req_target_i == tgt_ram);

  // write lanes whose strobe is set
  always_ff @(posedge clk) begin
    if (sel) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (req_wstrb_i[lane]) begin
          mem[word_idx][lane*8 +: 8] <= req_wdata_i[lane*8 +: 8];
        end
      end
    end
  end

  // registered read of the addressed word
  always_ff @(posedge clk) begin
    if (sel) begin
      ram_rdata_o <= mem[word_idx];
    end
  end

endmodule

/* soc_uart_tx.sv */
////////////////////////////////////////////////////////////////////////////
// UART transmitter, 8N1
// one start bit, eight data bits LSB first, one stop bit,
// each bit lasting div_i clocks
////////////////////////////////////////////////////////////////////////////

`include "soc_params.svh"

module soc_uart_tx import soc_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  logic        start_i,
  input  logic [7:0]  data_i,
  input  logic [15:0] div_i,
  output logic        busy_o,
  output logic        tx_o
);

  logic [8:0]  shift_q;
  logic [3:0]  bit_cnt_q;
  logic [15:0] div_cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // frame sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy_o    <= 1'b0;
      tx_o      <= 1'b1;
      bit_cnt_q <= 4'd0;
      div_cnt_q <= 16'd0;
    end else if (!busy_o) begin
      if (start_i) begin
        // start bit goes out right away
        busy_o    <= 1'b1;
        tx_o      <= 1'b0;
        bit_cnt_q <= 4'd0;
        div_cnt_q <= div_i - 16'd1;
      end
    end else if (div_cnt_q != 16'd0) begin
      div_cnt_q <= div_cnt_q - 16'd1;
    end else if (bit_cnt_q == 4'd9) begin
      // end of stop bit, line already high
      busy_o <= 1'b0;
    end else begin
      tx_o      <= shift_q[0];
      bit_cnt_q <= bit_cnt_q + 4'd1;
      div_cnt_q <= div_i - 16'd1;
    end
  end

  // data bits then stop bit, refilled with ones
  always_ff @(posedge clk) begin
    if (!busy_o && start_i) begin
      shift_q <= {1'b1, data_i};
    end else if (busy_o && div_cnt_q == 16'd0 && bit_cnt_q != 4'd9) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  // the register block must hold a byte back while a frame is on the line
  a_no_start_busy : assert property (@(posedge clk) disable iff (!resetn)
    start_i |-> !busy_o);

endmodule

/* soc_io_regs.sv */
////////////////////////////////////////////////////////////////////////////
// I/O register block
// divisor, clock frequency and memory size words, UART data and status
////////////////////////////////////////////////////////////////////////////

`include "soc_params.svh"

module soc_io_regs import soc_pkg::*; (
  input  logic    clk,
  input  logic    resetn,
  input  logic    req_fire_i,
  input  target_e req_target_i,
  input  data_t   req_wdata_i,
  input  wstrb_t  req_wstrb_i,
  output data_t   io_rdata_o,
  output logic    uart_tx_o
);

  logic [15:0] div_q;
  logic        wr;
  logic        div_wr;
  logic        tx_start;
  logic        tx_busy;
  logic        tx_idle;

  assign wr       = req_fire_i && (|req_wstrb_i);
  assign div_wr   = wr && (req_target_i == tgt_div);
  // byte is dropped while a frame is running
  assign tx_start = wr && (req_target_i == tgt_uart_data) && !tx_busy;
  assign tx_idle  = !tx_busy;

  // shared clock divisor, low half only
  always_ff @(posedge clk) begin
    if (!resetn) begin
      div_q <= 16'(`SOC_DIV_RESET);
    end else if (div_wr) begin
      div_q <= req_wdata_i[15:0];
    end
  end

  // read-back
  always_ff @(posedge clk) begin
    if (req_fire_i) begin
      case (req_target_i)
        tgt_div:      io_rdata_o <= {16'd0, div_q};
        tgt_freq:     io_rdata_o <= data_t'(`SOC_SYSTEM_CLK);
        tgt_mem_size: io_rdata_o <= data_t'(`SOC_MEM_SIZE);
        // transmitter empty flags in bits 14 and 13
        tgt_uart_lsr: io_rdata_o <= {17'd0, tx_idle, tx_idle, 13'd0};
        default:      io_rdata_o <= '0;
      endcase
    end
  end

  soc_uart_tx soc_uart_tx_inst (
    .clk     (clk),
    .resetn  (resetn),
    .start_i (tx_start),
    .data_i  (req_wdata_i[7:0]),
    .div_i   (div_q),
    .busy_o  (tx_busy),
    .tx_o    (uart_tx_o)
  );

  // a nonzero divisor stays nonzero until software rewrites it
  a_div_stable : assert property (@(posedge clk) disable iff (!resetn)
    (div_q != 16'd0) && !div_wr |=> div_q != 16'd0);

endmodule

/* soc_resp_mux.sv */
////////////////////////////////////////////////////////////////////////////
// response stage
// ready pulse, access fault and read data selection
////////////////////////////////////////////////////////////////////////////

`include "soc_params.svh"

module soc_resp_mux import soc_pkg::*; (
  input  logic    clk,
  input  logic    resetn,
  input  logic    req_fire_i,
  input  target_e req_target_i,
  input  data_t   ram_rdata_i,
  input  data_t   io_rdata_i,
  output logic    mem_ready_o,
  output data_t   mem_rdata_o,
  output logic    mem_fault_o
);

  target_e target_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      mem_ready_o <= 1'b0;
      mem_fault_o <= 1'b0;
    end else begin
      mem_ready_o <= req_fire_i;
      mem_fault_o <= req_fire_i && (req_target_i == tgt_unmapped);
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire_i) begin
      target_q <= req_target_i;
    end
  end

  // data lines up with the ready cycle
  always_comb begin
    case (target_q)
      tgt_ram:      mem_rdata_o = ram_rdata_i;
      tgt_unmapped: mem_rdata_o = '0;
      default:      mem_rdata_o = io_rdata_i;
    endcase
  end

  a_fault_ready : assert property (@(posedge clk) disable iff (!resetn)
    mem_fault_o |-> mem_ready_o);

endmodule

/* soc_bus.sv */
////////////////////////////////////////////////////////////////////////////
// memory-mapped subsystem top level
// request stage, boot RAM and I/O registers, response stage
////////////////////////////////////////////////////////////////////////////

`include "soc_params.svh"

module soc_bus import soc_pkg::*; (
  input  logic   clk,
  input  logic   resetn,
  input  logic   mem_valid_i,
  input  addr_t  mem_addr_i,
  input  data_t  mem_wdata_i,
  input  wstrb_t mem_wstrb_i,
  output logic   mem_ready_o,
  output data_t  mem_rdata_o,
  output logic   mem_fault_o,
  output logic   uart_tx_o
);

  logic    req_fire;
  target_e req_target;
  addr_t   req_addr;
  data_t   req_wdata;
  wstrb_t  req_wstrb;
  data_t   ram_rdata;
  data_t   io_rdata;

  soc_addr_decode soc_addr_decode_inst (
    .clk          (clk),
    .resetn       (resetn),
    .mem_valid_i  (mem_valid_i),
    .mem_addr_i   (mem_addr_i),
    .mem_wdata_i  (mem_wdata_i),
    .mem_wstrb_i  (mem_wstrb_i),
    .req_fire_o   (req_fire),
    .req_target_o (req_target),
    .req_addr_o   (req_addr),
    .req_wdata_o  (req_wdata),
    .req_wstrb_o  (req_wstrb)
  );

  soc_boot_ram soc_boot_ram_inst (
    .clk          (clk),
    .req_fire_i   (req_fire),
    .req_target_i (req_target),
    .req_addr_i   (req_addr),
    .req_wdata_i  (req_wdata),
    .req_wstrb_i  (req_wstrb),
    .ram_rdata_o  (ram_rdata)
  );

  soc_io_regs soc_io_regs_inst (
    .clk          (clk),
    .resetn       (resetn),
    .req_fire_i   (req_fire),
    .req_target_i (req_target),
    .req_wdata_i  (req_wdata),
    .req_wstrb_i  (req_wstrb),
    .io_rdata_o   (io_rdata),
    .uart_tx_o    (uart_tx_o)
  );

  soc_resp_mux soc_resp_mux_inst (
    .clk          (clk),
    .resetn       (resetn),
    .req_fire_i   (req_fire),
    .req_target_i (req_target),
    .ram_rdata_i  (ram_rdata),
    .io_rdata_i   (io_rdata),
    .mem_ready_o  (mem_ready_o),
    .mem_rdata_o  (mem_rdata_o),
    .mem_fault_o  (mem_fault_o)
  );

endmodule

/* tb_soc_bus.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the memory-mapped subsystem
// clock and reset, bus access task, typed compare tasks,
// directed tests for RAM, latency, system words, faults and UART
////////////////////////////////////////////////////////////////////////////

`include "soc_params.svh"

module tb_soc_bus import soc_pkg::*; ();

  logic   clk;
  logic   resetn;
  logic   mem_valid_i;
  addr_t  mem_addr_i;
  data_t  mem_wdata_i;
  wstrb_t mem_wstrb_i;
  logic   mem_ready_o;
  data_t  mem_rdata_o;
  logic   mem_fault_o;
  logic   uart_tx_o;

  int errors;
  int timeouts;

  soc_bus soc_bus_inst (
    .clk         (clk),
    .resetn      (resetn),
    .mem_valid_i (mem_valid_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_wstrb_i (mem_wstrb_i),
    .mem_ready_o (mem_ready_o),
    .mem_rdata_o (mem_rdata_o),
    .mem_fault_o (mem_fault_o),
    .uart_tx_o   (uart_tx_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus master
  ////////////////////////////////////////////////////////////////////////////

  // issues one request and returns data, fault bit and ready latency
  task automatic bus_access(input addr_t addr, input data_t wdata, input wstrb_t wstrb,
                            output data_t rdata, output logic fault, output int cycles);
    cycles = 0;
    rdata  = '0;
    fault  = 1'b0;
    @(negedge clk);
    mem_valid_i = 1'b1;
    mem_addr_i  = addr;
    mem_wdata_i = wdata;
    mem_wstrb_i = wstrb;
    do begin
      @(negedge clk);
      cycles++;
    end while (!mem_ready_o && cycles < 20);
    if (mem_ready_o) begin
      rdata = mem_rdata_o;
      fault = mem_fault_o;
    end else begin
      $display("no ready within 20 cycles for access to address %h", addr);
      timeouts++;
    end
    mem_valid_i = 1'b0;
    mem_wstrb_i = '0;
  endtask

  // write to a mapped address that must not fault
  task automatic bus_write(input addr_t addr, input data_t wdata, input wstrb_t wstrb);
    data_t rd;
    logic  flt;
    int    cyc;
    bus_access(addr, wdata, wstrb, rd, flt, cyc);
    check_flag("write fault", 1'b0, flt);
  endtask

  // poll line status until both transmitter empty bits are set
  task automatic wait_tx_idle();
    data_t rd;
    logic  flt;
    int    cyc;
    int    polls;
    polls = 0;
    do begin
      bus_access(`SOC_UART_LSR_ADDR, '0, '0, rd, flt, cyc);
      polls++;
    end while ((rd & 32'h6000) != 32'h6000 && polls < 40);
    if ((rd & 32'h6000) != 32'h6000) begin
      $display("line status never showed the transmitter idle");
      timeouts++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_ram();
    data_t  exp_mem [`SOC_BRAM_WORDS];
    int     idx_q[$];
    int     idx;
    data_t  wd;
    data_t  rd;
    logic   flt;
    int     cyc;
    for (int i = 0; i < 8; i++) begin
      idx = $urandom_range(`SOC_BRAM_WORDS - 1, 0);
      exp_mem[idx] = $urandom;
      idx_q.push_back(idx);
      bus_write(addr_t'(idx * 4), exp_mem[idx], 4'hf);
    end
    foreach (idx_q[i]) begin
      bus_access(addr_t'(idx_q[i] * 4), '0, '0, rd, flt, cyc);
      check_data("ram readback", exp_mem[idx_q[i]], rd);
      check_flag("ram read fault", 1'b0, flt);
    end
    // one lane at a time while the others keep their bytes
    idx = idx_q[0];
    for (int lane = 0; lane < 4; lane++) begin
      wd = $urandom;
      exp_mem[idx][lane*8 +: 8] = wd[lane*8 +: 8];
      bus_write(addr_t'(idx * 4), wd, wstrb_t'(1 << lane));
      bus_access(addr_t'(idx * 4), '0, '0, rd, flt, cyc);
      check_data("ram byte lane", exp_mem[idx], rd);
    end
  endtask

  task automatic test_latency();
    data_t rd;
    logic  flt;
    int    cyc;
    bus_access(32'h0000_0000, '0, '0, rd, flt, cyc);
    check_data("ready latency", data_t'(2), data_t'(cyc));
    @(negedge clk);
    check_flag("ready pulse width", 1'b0, mem_ready_o);
  endtask

  task automatic test_sysinfo();
    data_t rd;
    data_t wd;
    logic  flt;
    int    cyc;
    bus_access(`SOC_CPU_FREQ_ADDR, '0, '0, rd, flt, cyc);
    check_data("clock frequency word", data_t'(`SOC_SYSTEM_CLK), rd);
    check_flag("frequency fault", 1'b0, flt);
    bus_access(`SOC_MEM_SIZE_ADDR, '0, '0, rd, flt, cyc);
    check_data("memory size word", data_t'(`SOC_MEM_SIZE), rd);
    check_flag("memory size fault", 1'b0, flt);
    bus_access(`SOC_DIV_ADDR, '0, '0, rd, flt, cyc);
    check_data("divisor after reset", data_t'(`SOC_DIV_RESET), rd);
    check_flag("divisor read fault", 1'b0, flt);
    // keep the divisor nonzero
    wd = $urandom;
    if (wd[15:0] == 16'd0) begin
      wd[0] = 1'b1;
    end
    bus_write(`SOC_DIV_ADDR, wd, 4'hf);
    bus_access(`SOC_DIV_ADDR, '0, '0, rd, flt, cyc);
    check_data("divisor write", {16'd0, wd[15:0]}, rd);
  endtask

  task automatic test_fault();
    data_t rd;
    logic  flt;
    int    cyc;
    bus_access(32'h2000_0000, '0, '0, rd, flt, cyc);
    check_flag("unmapped read fault", 1'b1, flt);
    check_data("unmapped read data", '0, rd);
    bus_access(32'h2000_0000, $urandom, 4'hf, rd, flt, cyc);
    check_flag("unmapped write fault", 1'b1, flt);
    check_data("unmapped write data", '0, rd);
    bus_access(32'h1000_0004, '0, '0, rd, flt, cyc);
    check_flag("gap read fault", 1'b1, flt);
    check_data("gap read data", '0, rd);
  endtask

  task automatic test_uart();
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;
    logic       stop_bit;
    data_t      rd;
    logic       flt;
    int         cyc;
    int         n;
    bus_write(`SOC_DIV_ADDR, 32'd8, 4'hf);
    wait_tx_idle();
    tx_byte = 8'($urandom);
    bus_write(`SOC_UART_TX_ADDR, {24'd0, tx_byte}, 4'h1);
    n = 0;
    while (uart_tx_o !== 1'b0 && n < 40) begin
      @(negedge clk);
      n++;
    end
    if (uart_tx_o !== 1'b0) begin
      $display("no start bit on the serial line after the data write");
      timeouts++;
    end else begin
      fork
        begin
          // middle of each 8-clock bit
          repeat (4) @(negedge clk);
          check_flag("uart start bit", 1'b0, uart_tx_o);
          for (int b = 0; b < 8; b++) begin
            repeat (8) @(negedge clk);
            rx_byte[b] = uart_tx_o;
          end
          repeat (8) @(negedge clk);
          stop_bit = uart_tx_o;
        end
        begin
          repeat (2) @(negedge clk);
          bus_access(`SOC_UART_LSR_ADDR, '0, '0, rd, flt, cyc);
          check_data("line status busy", '0, rd & 32'h6000);
        end
      join
      check_byte("uart data bits", tx_byte, rx_byte);
      check_flag("uart stop bit", 1'b1, stop_bit);
      wait_tx_idle();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    errors      = 0;
    timeouts    = 0;
    resetn      = 1'b0;
    mem_valid_i = 1'b0;
    mem_addr_i  = '0;
    mem_wdata_i = '0;
    mem_wstrb_i = '0;
    void'($urandom(32'hd67e));
    repeat (3) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;

    test_sysinfo();
    test_ram();
    test_latency();
    test_fault();
    test_uart();

    $display("errors: %0d  timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+.
soc_pkg.sv
soc_addr_decode.sv
soc_boot_ram.sv
soc_uart_tx.sv
soc_io_regs.sv
soc_resp_mux.sv
soc_bus.sv
tb_soc_bus.sv
